// File: Bender.yml
package:
  name: qdr_replay

sources:
  - include_dirs:
      - hw
    files:
      - hw/qdr_replay_pkg.sv
      - hw/replay_ctrl.sv
      - hw/replay_addr_cnt.sv
      - hw/pkt_mem.sv
      - hw/rd_data_fifo.sv
      - hw/qdr_replay_top.sv
  - target: simulation
    files:
      - sim/tb_qdr_replay.sv

// File: all.f
+incdir+hw
hw/qdr_replay_pkg.sv
hw/replay_ctrl.sv
hw/replay_addr_cnt.sv
hw/pkt_mem.sv
hw/rd_data_fifo.sv
hw/qdr_replay_top.sv
sim/tb_qdr_replay.sv

// File: hw/pkt_mem.sv
`timescale 1ns/1ps
`include "qdr_replay_macros.svh"

module pkt_mem (
   input  logic                      clk,
   input  logic                      wr_en_i,
   input  qdr_replay_pkg::addr_t     wr_addr_i,
   input  qdr_replay_pkg::mem_word_t wr_word_i,
   input  logic                      rd_en_i,
   input  qdr_replay_pkg::addr_t     rd_addr_i,
   output logic                      rd_valid_o,
   output qdr_replay_pkg::mem_word_t rd_word_o
);

   import qdr_replay_pkg::*;

   mem_word_t             mem [`QR_MEM_DEPTH];
   mem_word_t             word_pipe [`QR_RD_LAT];
   logic [`QR_RD_LAT-1:0] vld_pipe;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_word_i;
      end
   end

   // One read pipeline stage per cycle of latency
   always_ff @(posedge clk) begin
      vld_pipe[0]  <= rd_en_i;
      word_pipe[0] <= mem[rd_addr_i];
      for (int i = 1; i < `QR_RD_LAT; i++) begin
         vld_pipe[i]  <= vld_pipe[i-1];
         word_pipe[i] <= word_pipe[i-1];
      end
   end

   assign rd_valid_o = vld_pipe[`QR_RD_LAT-1];
   assign rd_word_o  = word_pipe[`QR_RD_LAT-1];

endmodule

// File: hw/qdr_replay_macros.svh
`ifndef QDR_REPLAY_MACROS_SVH
`define QDR_REPLAY_MACROS_SVH

// Stream word and byte enables
`define QR_DATA_W 64
`define QR_KEEP_W 8

// Packet memory geometry
`define QR_ADDR_W 10
`define QR_MEM_DEPTH 1024

// Cycles from read command to read data, as on the QDR user interface
`define QR_RD_LAT 2

// Read data FIFO holds 2**QR_FIFO_DEPTH_BITS words
`define QR_FIFO_DEPTH_BITS 4

`endif

// File: hw/qdr_replay_pkg.sv
`include "qdr_replay_macros.svh"

package qdr_replay_pkg;

   typedef logic [`QR_DATA_W-1:0] data_t;
   typedef logic [`QR_KEEP_W-1:0] keep_t;
   typedef logic [`QR_ADDR_W-1:0] addr_t;

   // Packed as {last, keep, data}
   typedef logic [`QR_DATA_W+`QR_KEEP_W:0] mem_word_t;

   typedef logic [31:0] count_t;

   typedef enum logic [1:0] {
      ST_CAPTURE,
      ST_STORED,
      ST_REPLAY,
      ST_DRAIN
   } replay_state_t;

endpackage

// File: hw/qdr_replay_top.sv
`timescale 1ns/1ps
`include "qdr_replay_macros.svh"

module qdr_replay_top (
   input  logic                   clk,
   input  logic                   rst_i,
   input  qdr_replay_pkg::data_t  s_tdata_i,
   input  qdr_replay_pkg::keep_t  s_tkeep_i,
   input  logic                   s_tlast_i,
   input  logic                   s_tvalid_i,
   output logic                   s_tready_o,
   output qdr_replay_pkg::data_t  m_tdata_o,
   output qdr_replay_pkg::keep_t  m_tkeep_o,
   output logic                   m_tlast_o,
   output logic                   m_tvalid_o,
   input  logic                   m_tready_i,
   input  logic                   wr_done_i,
   input  logic                   start_replay_i,
   input  qdr_replay_pkg::count_t replay_count_i,
   input  logic                   sw_rst_i,
   output logic                   replay_busy_o
);

   import qdr_replay_pkg::*;

   logic      cap_wr;
   logic      rd_issue;
   logic      load_end;
   logic      load_loops;
   logic      clear;
   addr_t     wr_addr;
   addr_t     rd_addr;
   logic      mem_full;
   logic      nothing_to_play;
   logic      last_read;
   logic      rd_valid;
   mem_word_t rd_word;
   logic      fifo_empty;
   logic      fifo_nearly_full;
   logic      fifo_drained;

   assign m_tvalid_o = !fifo_empty;

   replay_ctrl replay_ctrl (
      .clk                 (  clk                ),
      .rst_i               (  rst_i              ),
      .s_tvalid_i          (  s_tvalid_i         ),
      .wr_done_i           (  wr_done_i          ),
      .start_replay_i      (  start_replay_i     ),
      .sw_rst_i            (  sw_rst_i           ),
      .mem_full_i          (  mem_full           ),
      .nothing_to_play_i   (  nothing_to_play    ),
      .last_read_i         (  last_read          ),
      .fifo_nearly_full_i  (  fifo_nearly_full   ),
      .fifo_drained_i      (  fifo_drained       ),
      .s_tready_o          (  s_tready_o         ),
      .cap_wr_o            (  cap_wr             ),
      .rd_issue_o          (  rd_issue           ),
      .load_end_o          (  load_end           ),
      .load_loops_o        (  load_loops         ),
      .clear_o             (  clear              ),
      .replay_busy_o       (  replay_busy_o      )
   );

   replay_addr_cnt replay_addr_cnt (
      .clk                 (  clk                ),
      .rst_i               (  rst_i              ),
      .clear_i             (  clear              ),
      .cap_wr_i            (  cap_wr             ),
      .load_end_i          (  load_end           ),
      .load_loops_i        (  load_loops         ),
      .rd_issue_i          (  rd_issue           ),
      .replay_count_i      (  replay_count_i     ),
      .wr_addr_o           (  wr_addr            ),
      .rd_addr_o           (  rd_addr            ),
      .mem_full_o          (  mem_full           ),
      .nothing_to_play_o   (  nothing_to_play    ),
      .last_read_o         (  last_read          )
   );

   // Stands in for the QDR user interface
   pkt_mem pkt_mem (
      .clk                 (  clk                                  ),
      .wr_en_i             (  cap_wr                               ),
      .wr_addr_i           (  wr_addr                              ),
      .wr_word_i           (  {s_tlast_i, s_tkeep_i, s_tdata_i}    ),
      .rd_en_i             (  rd_issue                             ),
      .rd_addr_i           (  rd_addr                              ),
      .rd_valid_o          (  rd_valid                             ),
      .rd_word_o           (  rd_word                              )
   );

   rd_data_fifo #(
      .depth_bits          (  `QR_FIFO_DEPTH_BITS                  )
   ) rd_data_fifo (
      .clk                 (  clk                                  ),
      .rst_i               (  rst_i                                ),
      .wr_en_i             (  rd_valid                             ),
      .din_i               (  rd_word                              ),
      .rd_en_i             (  m_tready_i                           ),
      .rd_issue_i          (  rd_issue                             ),
      .dout_o              (  {m_tlast_o, m_tkeep_o, m_tdata_o}    ),
      .empty_o             (  fifo_empty                           ),
      .nearly_full_o       (  fifo_nearly_full                     ),
      .drained_o           (  fifo_drained                         )
   );

endmodule

// File: hw/rd_data_fifo.sv
`timescale 1ns/1ps
`include "qdr_replay_macros.svh"

module rd_data_fifo #(
   parameter int depth_bits = 4
) (
   input  logic                      clk,
   input  logic                      rst_i,
   input  logic                      wr_en_i,
   input  qdr_replay_pkg::mem_word_t din_i,
   input  logic                      rd_en_i,
   input  logic                      rd_issue_i,
   output qdr_replay_pkg::mem_word_t dout_o,
   output logic                      empty_o,
   output logic                      nearly_full_o,
   output logic                      drained_o
);

   import qdr_replay_pkg::*;

   localparam int depth = 1 << depth_bits;
   // Room kept back for reads already on their way from memory
   localparam int high_mark = depth - `QR_RD_LAT - 1;

   mem_word_t                          store [depth];
   logic [depth_bits-1:0]              wr_ptr;
   logic [depth_bits-1:0]              rd_ptr;
   logic [depth_bits:0]                fill;
   logic [$clog2(`QR_RD_LAT+1)-1:0]    in_flight;
   logic                               pop;

   assign pop = rd_en_i && !empty_o;

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         store[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         in_flight <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en_i, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         // Each issued read comes back as exactly one write
         case ({rd_issue_i, wr_en_i})
            2'b10:   in_flight <= in_flight + 1'b1;
            2'b01:   in_flight <= in_flight - 1'b1;
            default: in_flight <= in_flight;
         endcase
      end
   end

   // First word falls through
   assign dout_o        = store[rd_ptr];
   assign empty_o       = (fill == '0);
   assign nearly_full_o = (fill >= high_mark);
   assign drained_o     = empty_o && (in_flight == '0);

endmodule

// File: hw/replay_addr_cnt.sv
`timescale 1ns/1ps
`include "qdr_replay_macros.svh"

module replay_addr_cnt (
   input  logic                   clk,
   input  logic                   rst_i,
   input  logic                   clear_i,
   input  logic                   cap_wr_i,
   input  logic                   load_end_i,
   input  logic                   load_loops_i,
   input  logic                   rd_issue_i,
   input  qdr_replay_pkg::count_t replay_count_i,
   output qdr_replay_pkg::addr_t  wr_addr_o,
   output qdr_replay_pkg::addr_t  rd_addr_o,
   output logic                   mem_full_o,
   output logic                   nothing_to_play_o,
   output logic                   last_read_o
);

   import qdr_replay_pkg::*;

   // Word count is one bit wider than the address so a full memory shows up
   logic [`QR_ADDR_W:0] wr_cnt;
   logic [`QR_ADDR_W:0] wr_cnt_nxt;
   addr_t               last_addr;
   logic                has_data;
   addr_t               rd_addr;
   count_t              loops_left;
   logic                at_end;

   assign wr_cnt_nxt = wr_cnt + {{`QR_ADDR_W{1'b0}}, cap_wr_i};
   assign wr_addr_o  = wr_cnt[`QR_ADDR_W-1:0];
   assign mem_full_o = wr_cnt[`QR_ADDR_W];

   always_ff @(posedge clk) begin
      if (rst_i || clear_i) begin
         wr_cnt    <= '0;
         last_addr <= '0;
         has_data  <= 1'b0;
      end else begin
         wr_cnt <= wr_cnt_nxt;
         if (load_end_i) begin
            // A word accepted alongside wr_done is still part of the capture
            last_addr <= wr_cnt_nxt[`QR_ADDR_W-1:0] - 1'b1;
            has_data  <= (wr_cnt_nxt != '0);
         end
      end
   end

   assign at_end            = (rd_addr == last_addr);
   assign rd_addr_o         = rd_addr;
   assign last_read_o       = at_end && (loops_left == count_t'(1));
   assign nothing_to_play_o = !has_data || (replay_count_i == '0);

   always_ff @(posedge clk) begin
      if (rst_i || clear_i) begin
         rd_addr    <= '0;
         loops_left <= '0;
      end else if (load_loops_i) begin
         rd_addr    <= '0;
         loops_left <= replay_count_i;
      end else if (rd_issue_i) begin
         if (at_end) begin
            // Wrap for the next pass
            rd_addr    <= '0;
            loops_left <= loops_left - 1'b1;
         end else begin
            rd_addr <= rd_addr + 1'b1;
         end
      end
   end

endmodule

// File: hw/replay_ctrl.sv
`timescale 1ns/1ps

module replay_ctrl (
   input  logic clk,
   input  logic rst_i,
   input  logic s_tvalid_i,
   input  logic wr_done_i,
   input  logic start_replay_i,
   input  logic sw_rst_i,
   input  logic mem_full_i,
   input  logic nothing_to_play_i,
   input  logic last_read_i,
   input  logic fifo_nearly_full_i,
   input  logic fifo_drained_i,
   output logic s_tready_o,
   output logic cap_wr_o,
   output logic rd_issue_o,
   output logic load_end_o,
   output logic load_loops_o,
   output logic clear_o,
   output logic replay_busy_o
);

   import qdr_replay_pkg::*;

   replay_state_t state;
   replay_state_t state_nxt;
   logic          in_capture;
   logic          in_stored;
   logic          in_replay;
   logic          in_drain;

   assign in_capture = (state == ST_CAPTURE);
   assign in_stored  = (state == ST_STORED);
   assign in_replay  = (state == ST_REPLAY);
   assign in_drain   = (state == ST_DRAIN);

   // Capture side
   assign s_tready_o = in_capture && !mem_full_i;
   assign cap_wr_o   = s_tready_o && s_tvalid_i;
   assign load_end_o = in_capture && wr_done_i;

   // Reads pause while the FIFO has no room for in-flight data
   assign load_loops_o = in_stored && start_replay_i;
   assign rd_issue_o   = in_replay && !fifo_nearly_full_i;

   assign clear_o       = sw_rst_i;
   assign replay_busy_o = in_replay || in_drain;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_CAPTURE: begin
            if (wr_done_i) begin
               state_nxt = ST_STORED;
            end
         end
         ST_STORED: begin
            // A zero loop count or an empty capture is simply ignored
            if (start_replay_i && !nothing_to_play_i) begin
               state_nxt = ST_REPLAY;
            end
         end
         ST_REPLAY: begin
            if (rd_issue_o && last_read_i) begin
               state_nxt = ST_DRAIN;
            end
         end
         ST_DRAIN: begin
            if (fifo_drained_i) begin
               state_nxt = ST_STORED;
            end
         end
         default: begin
            state_nxt = ST_CAPTURE;
         end
      endcase
      if (sw_rst_i) begin
         state_nxt = ST_CAPTURE;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state <= ST_CAPTURE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

// File: sim/tb_qdr_replay.sv
`timescale 1ns/1ps

module tb_qdr_replay;

   import qdr_replay_pkg::*;

   localparam int wait_limit = 4000;

   logic      clk;
   logic      rst_i;
   data_t     s_tdata_i;
   keep_t     s_tkeep_i;
   logic      s_tlast_i;
   logic      s_tvalid_i;
   logic      s_tready_o;
   data_t     m_tdata_o;
   keep_t     m_tkeep_o;
   logic      m_tlast_o;
   logic      m_tvalid_o;
   logic      m_tready_i;
   logic      wr_done_i;
   logic      start_replay_i;
   count_t    replay_count_i;
   logic      sw_rst_i;
   logic      replay_busy_o;

   mem_word_t m_word;
   mem_word_t cap_q[$];
   mem_word_t exp_q[$];
   string     test_name;
   logic      stall_pend;
   mem_word_t stall_word;

   assign m_word = {m_tlast_o, m_tkeep_o, m_tdata_o};

   qdr_replay_top uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic value_error(input string name, input mem_word_t exp, input mem_word_t act);
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic plain_error(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // Output side scoreboard
   always @(posedge clk) begin
      if (!rst_i) begin
         if (stall_pend) begin
            assert (m_word == stall_word)
            else value_error({test_name, " hold"}, stall_word, m_word);
         end
         if (m_tvalid_o && m_tready_i) begin
            assert (exp_q.size() > 0) else plain_error("output word appeared with none expected");
            assert (m_word == exp_q[0]) else value_error(test_name, exp_q[0], m_word);
            void'(exp_q.pop_front());
         end
         stall_pend = m_tvalid_o && !m_tready_i;
         stall_word = m_word;
      end
   end

   assert property (@(posedge clk) disable iff (rst_i)
      m_tvalid_o && !m_tready_i |=> m_tvalid_o)
   else plain_error("m_tvalid_o dropped while an output word was stalled");

   task automatic send_packet(input int len);
      mem_word_t w;
      int        t;
      for (int i = 0; i < len; i++) begin
         w = {(i == len - 1), keep_t'($urandom), $urandom, $urandom};
         {s_tlast_i, s_tkeep_i, s_tdata_i} = w;
         s_tvalid_i = 1'b1;
         t = 0;
         do begin
            @(posedge clk);
            t++;
            if (t > wait_limit) plain_error("input word was never accepted");
         end while (!s_tready_o);
         cap_q.push_back(w);
         #1;
      end
      s_tvalid_i = 1'b0;
   endtask

   task automatic capture_packets(input int n);
      for (int p = 0; p < n; p++) begin
         send_packet($urandom_range(1, 6));
      end
      wr_done_i = 1'b1;
      next_cycle();
      wr_done_i = 1'b0;
      assert (s_tready_o == 1'b0) else value_error({test_name, " s_tready"}, 0, s_tready_o);
   endtask

   // Busy is sampled on the edge and m_tready_i moves 1 ns later
   task automatic wait_busy(input logic level, input logic random_ready);
      int   t;
      logic seen;
      t = 0;
      do begin
         @(posedge clk);
         seen = replay_busy_o;
         t++;
         if (t > wait_limit) plain_error("replay_busy_o never reached the expected level");
         assert (s_tready_o == 1'b0) else value_error({test_name, " s_tready"}, 0, s_tready_o);
         #1;
         if (random_ready) m_tready_i = ($urandom_range(0, 3) == 0);
      end while (seen != level);
   endtask

   task automatic run_replay(input int count, input logic random_ready);
      exp_q.delete();
      for (int l = 0; l < count; l++) begin
         foreach (cap_q[i]) begin
            exp_q.push_back(cap_q[i]);
         end
      end
      replay_count_i = count;
      start_replay_i = 1'b1;
      next_cycle();
      start_replay_i = 1'b0;
      wait_busy(1'b1, random_ready);
      wait_busy(1'b0, random_ready);
      m_tready_i = 1'b1;
      repeat (4) begin
         @(posedge clk);
         assert (m_tvalid_o == 1'b0) else value_error({test_name, " m_tvalid"}, 0, m_tvalid_o);
      end
      #1;
      assert (exp_q.size() == 0) else value_error({test_name, " words left"}, 0, exp_q.size());
   endtask

   initial begin
      void'($urandom(32'hd2e3));
      rst_i          = 1'b1;
      s_tdata_i      = '0;
      s_tkeep_i      = '0;
      s_tlast_i      = 1'b0;
      s_tvalid_i     = 1'b0;
      m_tready_i     = 1'b1;
      wr_done_i      = 1'b0;
      start_replay_i = 1'b0;
      replay_count_i = '0;
      sw_rst_i       = 1'b0;
      stall_pend     = 1'b0;
      stall_word     = '0;
      test_name      = "reset";
      repeat (8) @(posedge clk);
      #1;
      rst_i = 1'b0;
      assert (s_tready_o == 1'b1) else value_error("reset s_tready", 1, s_tready_o);
      assert (m_tvalid_o == 1'b0) else value_error("reset m_tvalid", 0, m_tvalid_o);
      assert (replay_busy_o == 1'b0) else value_error("reset busy", 0, replay_busy_o);

      test_name = "single_replay";
      capture_packets(3);
      run_replay(1, 1'b0);

      test_name = "triple_replay";
      run_replay(3, 1'b0);

      // Enough loops and little ready so the FIFO reaches its nearly-full mark
      test_name = "backpressure";
      run_replay(6, 1'b1);

      // A zero loop count is ignored by the FSM
      test_name = "zero_count";
      replay_count_i = '0;
      start_replay_i = 1'b1;
      next_cycle();
      start_replay_i = 1'b0;
      repeat (8) begin
         @(posedge clk);
         assert (replay_busy_o == 1'b0) else value_error("zero_count busy", 0, replay_busy_o);
      end
      #1;

      test_name = "sw_reset";
      sw_rst_i = 1'b1;
      next_cycle();
      sw_rst_i = 1'b0;
      assert (s_tready_o == 1'b1) else value_error("sw_reset s_tready", 1, s_tready_o);
      cap_q.delete();
      capture_packets(1);
      run_replay(1, 1'b0);

      $display("** PASS **");
      $finish;
   end

endmodule
